//--- hw/byte_packer.sv
// Byte packer that turns four file index 0 bytes into a word and its address
`timescale 1ns/1ns
`include "rom_loader_params.svh"

module byte_packer import rom_pkg::*; (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        ioctl_download,
	input  logic                        ioctl_wr,
	input  logic [`ROM_ADDR_W-1:0]      ioctl_addr,
	input  logic [`ROM_INDEX_W-1:0]     ioctl_index,
	input  logic [7:0]                  ioctl_dout,
	output logic                        push,
	output rom_word_u                   push_word,
	output logic [`ROM_WORD_ADDR_W-1:0] push_waddr
);

	logic [23:0] acc_bytes; // Last three bytes, oldest high
	logic        take_byte; // Byte belongs to the ROM image
	logic        word_end;  // Fourth byte of a word

	assign take_byte = ioctl_wr && ioctl_download && (ioctl_index == '0);
	assign word_end  = take_byte && (ioctl_addr[1:0] == 2'b11);

	// Byte history
	always_ff @(posedge clk_sys) begin
		if (take_byte) begin
			acc_bytes <= {acc_bytes[15:0], ioctl_dout}; // Shift in at the bottom
		end
	end

	// Word and address capture on the last byte
	always_ff @(posedge clk_sys) begin
		if (word_end) begin
			push_word.whole <= {acc_bytes, ioctl_dout};
			push_waddr      <= ioctl_addr[`ROM_ADDR_W-1:2]; // Drop byte lane
		end
	end

	// Push strobe, one cycle after the fourth byte
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			push <= 1'b0;
		end else begin
			push <= word_end;
		end
	end

endmodule

//--- hw/region_writer.sv
// ROM map decoder and four-phase memory writer for queued words
`timescale 1ns/1ns
`include "rom_loader_params.svh"

module region_writer import rom_pkg::*; (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        pop_valid,
	input  rom_word_u                   pop_word,
	input  logic [`ROM_WORD_ADDR_W-1:0] pop_waddr,
	input  logic                        mem_ack,
	output logic                        pop,
	output logic                        mem_req,
	output logic [`ROM_ADDR_W-1:0]      mem_addr,
	output logic [31:0]                 mem_data,
	output region_e                     mem_region
);

	typedef enum logic [1:0] {
		ST_IDLE, // Waiting for a head word
		ST_REQ,  // mem_req high, waiting for ack
		ST_REL,  // mem_req low, waiting for ack to drop
		ST_NEXT  // Pop cycle
	} state_e;

	state_e      state;
	region_e     head_region; // Region of the head word
	logic [2:0]  n_items;     // Writes per word
	logic [1:0]  item_cnt;    // Item in flight
	logic [1:0]  sel_idx;     // Item to load next
	logic [1:0]  item_off;    // Byte offset of that item
	logic [31:0] item_data;
	logic        last_item;
	logic        load_item;

	function automatic logic in_range(input logic [`ROM_WORD_ADDR_W-1:0] a,
		input logic [`ROM_WORD_ADDR_W-1:0] lo, input logic [`ROM_WORD_ADDR_W-1:0] hi);
		return (a >= lo) && (a < hi);
	endfunction

	function automatic region_e decode_region(input logic [`ROM_WORD_ADDR_W-1:0] a);
		if (in_range(a, `ROM_GFX_LO, `ROM_GFX_HI))   return REG_GFX;
		if (in_range(a, `ROM_9AB_LO, `ROM_9AB_HI))   return REG_CPU_9AB;
		if (in_range(a, `ROM_10AB_LO, `ROM_10AB_HI)) return REG_CPU_10AB;
		if (in_range(a, `ROM_7AB_LO, `ROM_7AB_HI))   return REG_CPU_7AB;
		if (in_range(a, `ROM_6AB_LO, `ROM_6AB_HI))   return REG_CPU_6AB;
		if (in_range(a, `ROM_5AB_LO, `ROM_5AB_HI))   return REG_CPU_5AB;
		if (in_range(a, `ROM_3AB_LO, `ROM_3AB_HI))   return REG_CPU_3AB;
		if (in_range(a, `ROM_16S_LO, `ROM_16S_HI))   return REG_AUD_16S;
		if (in_range(a, `ROM_16R_LO, `ROM_16R_HI))   return REG_AUD_16R;
		if (in_range(a, `ROM_6P_LO, `ROM_6P_HI))     return REG_CHR_6P;
		return REG_NONE; // Filler gap
	endfunction

	// ############################################################
	// Head word decode
	// ############################################################
	assign head_region = decode_region(pop_waddr);
	assign sel_idx     = (state == ST_IDLE) ? 2'd0 : item_cnt + 2'd1;
	assign last_item   = ({1'b0, item_cnt} == n_items - 3'd1);

	always_comb begin
		n_items   = 3'd0;
		item_off  = 2'd0;
		item_data = pop_word.whole;
		case (head_region)
			REG_GFX: n_items = 3'd1; // Whole dword
			REG_CPU_9AB, REG_CPU_10AB, REG_CPU_7AB, REG_CPU_6AB, REG_CPU_5AB,
			REG_CPU_3AB: begin
				n_items   = 3'd2;
				item_off  = {sel_idx[0], 1'b0};
				item_data = {16'h0, pop_word.halves[~sel_idx[0]]}; // High half first
			end
			REG_AUD_16S, REG_AUD_16R, REG_CHR_6P: begin
				n_items   = 3'd4;
				item_off  = sel_idx;
				item_data = {24'h0, pop_word.bytes[~sel_idx]}; // Arrival order
			end
			default: n_items = 3'd0; // Nothing to write
		endcase
	end

	// Start of a word or the next item after ack drops
	assign load_item = ((state == ST_IDLE) && pop_valid && (n_items != 3'd0)) ||
		((state == ST_REL) && !mem_ack && !last_item);

	// ############################################################
	// Handshake FSM
	// ############################################################
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= ST_IDLE;
			mem_req  <= 1'b0;
			pop      <= 1'b0;
			item_cnt <= 2'd0;
		end else begin
			pop <= 1'b0; // Strobe
			case (state)
				ST_IDLE: begin
					if (pop_valid && n_items == 3'd0) begin
						pop   <= 1'b1; // Drop filler
						state <= ST_NEXT;
					end else if (load_item) begin
						mem_req  <= 1'b1;
						item_cnt <= 2'd0;
						state    <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
						state   <= ST_REL;
					end
				end
				ST_REL: begin
					if (!mem_ack && last_item) begin
						pop   <= 1'b1;
						state <= ST_NEXT;
					end else if (load_item) begin
						mem_req  <= 1'b1;
						item_cnt <= sel_idx;
						state    <= ST_REQ;
					end
				end
				default: state <= ST_IDLE; // ST_NEXT, old head still shown
			endcase
		end
	end

	// Item payload, held through the handshake
	always_ff @(posedge clk_sys) begin
		if (load_item) begin
			mem_addr   <= {pop_waddr, item_off};
			mem_data   <= item_data;
			mem_region <= head_region;
		end
	end

endmodule

//--- hw/rom_loader.sv
// ROM download path top with packer, word FIFO and region writer
`timescale 1ns/1ns
`include "rom_loader_params.svh"

module rom_loader import rom_pkg::*; (
	input  logic                    clk_sys,
	input  logic                    reset,
	// Host download port
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic [`ROM_ADDR_W-1:0]  ioctl_addr,
	input  logic [`ROM_INDEX_W-1:0] ioctl_index,
	input  logic [7:0]              ioctl_dout,
	output logic                    ioctl_wait,
	// Memory port, four-phase
	output logic                    mem_req,
	input  logic                    mem_ack,
	output logic [`ROM_ADDR_W-1:0]  mem_addr,
	output logic [31:0]             mem_data,
	output region_e                 mem_region
);

	logic                        push;
	rom_word_u                   push_word;
	logic [`ROM_WORD_ADDR_W-1:0] push_waddr;
	logic                        pop;
	logic                        pop_valid;
	rom_word_u                   pop_word;
	logic [`ROM_WORD_ADDR_W-1:0] pop_waddr;

	byte_packer packer_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_index    (ioctl_index),
		.ioctl_dout     (ioctl_dout),
		.push           (push),
		.push_word      (push_word),
		.push_waddr     (push_waddr)
	);

	// Host is held off while the queue is full
	word_fifo #(
		.DEPTH (`FIFO_DEPTH)
	) fifo_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.push       (push),
		.push_word  (push_word),
		.push_waddr (push_waddr),
		.pop        (pop),
		.full       (ioctl_wait),
		.pop_valid  (pop_valid),
		.pop_word   (pop_word),
		.pop_waddr  (pop_waddr)
	);

	region_writer writer_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pop_valid  (pop_valid),
		.pop_word   (pop_word),
		.pop_waddr  (pop_waddr),
		.mem_ack    (mem_ack),
		.pop        (pop),
		.mem_req    (mem_req),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.mem_region (mem_region)
	);

endmodule

//--- hw/rom_loader_params.svh
// Download port widths, FIFO depth and ROM map word address bounds
`ifndef ROM_LOADER_PARAMS_SVH
`define ROM_LOADER_PARAMS_SVH

`define ROM_ADDR_W      25 // Download byte address
`define ROM_WORD_ADDR_W 23 // Byte address without bits [1:0]
`define ROM_INDEX_W     8  // File index from the host

`define FIFO_DEPTH      4  // Words queued, power of two

// ############################################################
// ROM map in word addresses, low inclusive, high exclusive
// ############################################################
`define ROM_GFX_LO   23'h000000 // Graphics, 32-bit interleaved
`define ROM_GFX_HI   23'h030000
`define ROM_9AB_LO   23'h030000 // CPU pairs, 16-bit interleaved
`define ROM_9AB_HI   23'h034000
`define ROM_10AB_LO  23'h03C000 // Gap below is filler
`define ROM_10AB_HI  23'h03E000
`define ROM_7AB_LO   23'h040000
`define ROM_7AB_HI   23'h044000
`define ROM_6AB_LO   23'h044000
`define ROM_6AB_HI   23'h048000
`define ROM_5AB_LO   23'h048000
`define ROM_5AB_HI   23'h04C000
`define ROM_3AB_LO   23'h04C000
`define ROM_3AB_HI   23'h050000
`define ROM_16S_LO   23'h050000 // Audio, plain bytes
`define ROM_16S_HI   23'h052000
`define ROM_16R_LO   23'h052000
`define ROM_16R_HI   23'h053000
`define ROM_6P_LO    23'h053000 // Char ROM, plain bytes
`define ROM_6P_HI    23'h054000

`endif

//--- hw/rom_pkg.sv
// ROM region names and the three-view word type of the loader
package rom_pkg;

	// Target ROM of one packed word
	typedef enum logic [3:0] {
		REG_GFX,      // Graphics, dword per word
		REG_CPU_9AB,
		REG_CPU_10AB,
		REG_CPU_7AB,
		REG_CPU_6AB,
		REG_CPU_5AB,
		REG_CPU_3AB,
		REG_AUD_16S,  // Audio, byte per item
		REG_AUD_16R,
		REG_CHR_6P,
		REG_NONE      // Filler, dropped
	} region_e;

	// One word as seen by the graphics, CPU and byte ROMs.
	// Index 3 of bytes and index 1 of halves hold what came first.
	typedef union packed {
		logic [31:0]      whole;  // Graphics dword
		logic [1:0][15:0] halves; // CPU pair, first half high
		logic [3:0][7:0]  bytes;  // Audio and char, first byte high
	} rom_word_u;

endpackage

//--- hw/word_fifo.sv
// Show-ahead FIFO of packed words and their word addresses
`timescale 1ns/1ns
`include "rom_loader_params.svh"

module word_fifo import rom_pkg::*; #(
	parameter int DEPTH = `FIFO_DEPTH
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  logic                        push,
	input  rom_word_u                   push_word,
	input  logic [`ROM_WORD_ADDR_W-1:0] push_waddr,
	input  logic                        pop,
	output logic                        full,
	output logic                        pop_valid,
	output rom_word_u                   pop_word,
	output logic [`ROM_WORD_ADDR_W-1:0] pop_waddr
);

	localparam int PTR_W = $clog2(DEPTH);

	rom_word_u                   word_mem [DEPTH];  // Word storage
	logic [`ROM_WORD_ADDR_W-1:0] waddr_mem [DEPTH]; // Matching addresses
	logic [PTR_W:0]              wr_ptr;            // Top bit is the wrap flag
	logic [PTR_W:0]              rd_ptr;
	logic                        do_push;
	logic                        do_pop;

	// Same slot, opposite lap means full
	assign full      = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
	assign pop_valid = (wr_ptr != rd_ptr);

	assign do_push = push && (!full || pop); // Full slot frees up on a pop
	assign do_pop  = pop && pop_valid;

	// Head entry straight to the outputs
	assign pop_word  = word_mem[rd_ptr[PTR_W-1:0]];
	assign pop_waddr = waddr_mem[rd_ptr[PTR_W-1:0]];

	always_ff @(posedge clk_sys) begin
		if (do_push) begin
			word_mem[wr_ptr[PTR_W-1:0]]  <= push_word;
			waddr_mem[wr_ptr[PTR_W-1:0]] <= push_waddr;
		end
	end

	// Pointers
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

//--- list.f
+incdir+hw
hw/rom_pkg.sv
hw/byte_packer.sv
hw/word_fifo.sv
hw/region_writer.sv
hw/rom_loader.sv
sim/rom_loader_chk.sv
sim/tb_rom_loader.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the ROM loader testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_rom_loader \
	--Mdir obj_dir \
	-f list.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Keep going after assertion errors so the testbench prints its own verdict
sim_out=$(./obj_dir/Vtb_rom_loader +verilator+error+limit+1000)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TESTBENCH PASSED" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi

//--- sim/rom_loader_chk.sv
// Bound assertions for the memory handshake, FIFO back-pressure and reset state
`timescale 1ns/1ns
`include "rom_loader_params.svh"

module rom_loader_chk import rom_pkg::*; (
	input logic                   clk_sys,
	input logic                   reset,
	input logic                   full,     // FIFO full drives ioctl_wait
	input logic                   push,
	input logic                   mem_req,
	input logic                   mem_ack,
	input logic [`ROM_ADDR_W-1:0] mem_addr,
	input logic [31:0]            mem_data,
	input region_e                mem_region
);

	int unsigned fail_cnt = 0; // Failed assertions so far

	// ############################################################
	// Four-phase handshake
	// ############################################################
	req_after_ack_low: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(mem_req) |-> !$past(mem_ack)) // Ack of the last write must be gone
		else begin
			fail_cnt++;
			$error("mem_req rose while mem_ack was still high");
		end

	req_held: assert property (@(posedge clk_sys) disable iff (reset)
		(mem_req && !mem_ack) |=> mem_req)
		else begin
			fail_cnt++;
			$error("mem_req dropped before mem_ack");
		end

	payload_stable: assert property (@(posedge clk_sys) disable iff (reset)
		(mem_req && !mem_ack) |=> ($stable(mem_addr) && $stable(mem_data) &&
		$stable(mem_region)))
		else begin
			fail_cnt++;
			$error("Write payload changed while the request was open");
		end

	// ############################################################
	// Back-pressure and reset
	// ############################################################
	no_push_when_full: assert property (@(posedge clk_sys) disable iff (reset)
		!(push && full))
		else begin
			fail_cnt++;
			$error("Word pushed into a full FIFO");
		end

	reset_state: assert property (@(posedge clk_sys)
		reset |=> (!mem_req && !full && !push)) // Quiet the cycle after a reset edge
		else begin
			fail_cnt++;
			$error("Outputs not idle after reset");
		end

endmodule

bind rom_loader rom_loader_chk chk_i (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.full       (ioctl_wait),
	.push       (push),
	.mem_req    (mem_req),
	.mem_ack    (mem_ack),
	.mem_addr   (mem_addr),
	.mem_data   (mem_data),
	.mem_region (mem_region)
);

//--- sim/tb_rom_loader.sv
// Testbench for the ROM loader with host model, memory responder and write checks
`timescale 1ns/1ns
`include "rom_loader_params.svh"

module tb_rom_loader import rom_pkg::*; ();

	localparam int P1_WORDS = 18;  // Map walk, filler and index 1 words
	localparam int BP_WORDS = 12;  // Back-pressure burst
	localparam int N_WORDS  = P1_WORDS + BP_WORDS;
	localparam int TIMEOUT  = 20 * 4 * N_WORDS + 200; // Cycles, 20 per byte

	logic                    clk_sys = 1'b0;
	logic                    reset;
	logic                    ioctl_download;
	logic                    ioctl_wr;
	logic [`ROM_ADDR_W-1:0]  ioctl_addr;
	logic [`ROM_INDEX_W-1:0] ioctl_index;
	logic [7:0]              ioctl_dout;
	logic                    ioctl_wait;
	logic                    mem_req;
	logic                    mem_ack;
	logic [`ROM_ADDR_W-1:0]  mem_addr;
	logic [31:0]             mem_data;
	region_e                 mem_region;

	logic [`ROM_ADDR_W-1:0]  exp_addr [$]; // Expected writes, in order
	logic [31:0]             exp_data [$];
	region_e                 exp_region [$];
	int                      errors = 0;
	int unsigned             chk_fails;
	int                      cycles;
	logic                    slow = 1'b0;     // Responder at its longest delay
	logic                    saw_wait = 1'b0;

	rom_loader dut_i (.*);

	always #50 clk_sys = ~clk_sys; // 100 ns period

	always @(posedge clk_sys) begin
		if (ioctl_wait) saw_wait <= 1'b1;
	end

	task automatic step();
		@(posedge clk_sys);
		#1; // Drive point
	endtask

	task automatic add_write(input logic [`ROM_ADDR_W-1:0] a, input logic [31:0] d,
		input region_e r);
		exp_addr.push_back(a);
		exp_data.push_back(d);
		exp_region.push_back(r);
	endtask

	// Writes one word must produce, straight from the ROM map rules
	task automatic expect_writes(input logic [`ROM_WORD_ADDR_W-1:0] waddr,
		input logic [31:0] word, input region_e r);
		case (r)
			REG_GFX: add_write({waddr, 2'd0}, word, r); // One dword
			REG_CPU_9AB, REG_CPU_10AB, REG_CPU_7AB, REG_CPU_6AB, REG_CPU_5AB,
			REG_CPU_3AB: begin
				add_write({waddr, 2'd0}, {16'h0, word[31:16]}, r); // High half first
				add_write({waddr, 2'd2}, {16'h0, word[15:0]}, r);
			end
			REG_AUD_16S, REG_AUD_16R, REG_CHR_6P: begin
				for (int k = 0; k < 4; k++) begin
					add_write({waddr, k[1:0]}, {24'h0, word[31-8*k -: 8]}, r);
				end
			end
			default: ; // Filler, nothing written
		endcase
	endtask

	task automatic send_byte(input logic [`ROM_INDEX_W-1:0] index,
		input logic [`ROM_ADDR_W-1:0] a, input logic [7:0] d);
		while (ioctl_wait) step(); // Host holds off
		ioctl_wr    = 1'b1;
		ioctl_index = index;
		ioctl_addr  = a;
		ioctl_dout  = d;
		step();
		ioctl_wr = 1'b0;
	endtask

	task automatic send_word(input logic [`ROM_INDEX_W-1:0] index,
		input logic [`ROM_WORD_ADDR_W-1:0] waddr, input region_e r);
		logic [31:0] word;
		word = $urandom;
		if (index == '0) expect_writes(waddr, word, r); // Other files never land
		for (int k = 0; k < 4; k++) begin
			send_byte(index, {waddr, k[1:0]}, word[31-8*k -: 8]); // First byte high
		end
	endtask

	task automatic check_write();
		logic [`ROM_ADDR_W-1:0] e_addr;
		logic [31:0]            e_data;
		region_e                e_region;
		assert (exp_addr.size() != 0) else begin
			errors++;
			$display("Unexpected write to address %h with data %h", mem_addr, mem_data);
		end
		if (exp_addr.size() != 0) begin
			e_addr   = exp_addr.pop_front();
			e_data   = exp_data.pop_front();
			e_region = exp_region.pop_front();
			assert (mem_addr == e_addr) else begin
				errors++;
				$display("[ERROR] mem_addr got %h expected %h", mem_addr, e_addr);
			end
			assert (mem_data == e_data) else begin
				errors++;
				$display("[ERROR] mem_data got %h expected %h", mem_data, e_data);
			end
			assert (mem_region == e_region) else begin
				errors++;
				$display("[ERROR] mem_region got %h expected %h", mem_region, e_region);
			end
		end
	endtask

	// ############################################################
	// Memory responder, random ack delay
	// ############################################################
	initial begin : responder
		int unsigned delay;
		forever begin
			step();
			if (mem_req && !mem_ack) begin
				delay = slow ? 5 : $urandom % 6;
				repeat (delay) step();
				check_write(); // Payload stable at the ack
				mem_ack = 1'b1;
			end else if (!mem_req && mem_ack) begin
				mem_ack = 1'b0; // Fourth phase
			end
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < TIMEOUT) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout after %0d cycles with %0d writes outstanding", cycles,
			exp_addr.size());
		$display("TESTBENCH FAILED");
		$finish;
	end

	// ############################################################
	// Download stimulus
	// ############################################################
	initial begin : stimulus
		void'($urandom(65));
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_index    = '0;
		ioctl_dout     = '0;
		mem_ack        = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1 reset = 1'b0;
		step();
		ioctl_download = 1'b1;

		// Graphics ends, one word per CPU pair, byte ROMs
		send_word(8'd0, 23'h000000, REG_GFX);
		send_word(8'd0, 23'h000001, REG_GFX);
		send_word(8'd0, 23'h02FFFE, REG_GFX);
		send_word(8'd0, 23'h02FFFF, REG_GFX);
		send_word(8'd0, 23'h030000, REG_CPU_9AB);
		send_word(8'd0, 23'h03DFFF, REG_CPU_10AB);
		send_word(8'd0, 23'h040000, REG_CPU_7AB);
		send_word(8'd0, 23'h047FFF, REG_CPU_6AB);
		send_word(8'd0, 23'h048000, REG_CPU_5AB);
		send_word(8'd0, 23'h04FFFF, REG_CPU_3AB);
		send_word(8'd0, 23'h050000, REG_AUD_16S);
		send_word(8'd0, 23'h052FFF, REG_AUD_16R);
		send_word(8'd0, 23'h053000, REG_CHR_6P);
		send_word(8'd0, 23'h034000, REG_NONE);   // Gap below 10A/10B
		send_word(8'd0, 23'h03BFFF, REG_NONE);
		send_word(8'd0, 23'h054000, REG_NONE);   // Past the char ROM
		send_word(8'd0, 23'h7FFFFF, REG_NONE);
		send_word(8'd1, 23'h000020, REG_NONE);   // Other file index
		while (exp_addr.size() != 0) step();

		// Slow memory, host runs into ioctl_wait
		slow = 1'b1;
		for (int n = 0; n < BP_WORDS; n++) begin
			case (n % 3)
				0:       send_word(8'd0, 23'h000100 + 23'(n), REG_GFX);
				1:       send_word(8'd0, 23'h040100 + 23'(n), REG_CPU_7AB);
				default: send_word(8'd0, 23'h050100 + 23'(n), REG_AUD_16S);
			endcase
		end
		while (exp_addr.size() != 0) step();
		ioctl_download = 1'b0;
		repeat (20) step(); // Room for stray writes

		chk_fails = dut_i.chk_i.fail_cnt;
		assert (saw_wait) else begin
			errors++;
			$display("ioctl_wait never rose under a slow memory");
		end
		$display("Closing counts: %0d check errors, %0d assertion failures, %0d cycles",
			errors, chk_fails, cycles);
		if (errors == 0 && chk_fails == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule
